/* hw/uart_cfg_pkg.sv */
////////////////////////////////////////////////////////////////////////////
// serial line constants: bit period, frame size, counter types
////////////////////////////////////////////////////////////////////////////
`default_nettype none

package uart_cfg_pkg;

    localparam int clks_per_bit = 16;               // any value of 4 or more
    localparam int data_bits    = 8;
    localparam int frame_bits   = data_bits + 2;    // start + data + stop

    localparam int cnt_w = $clog2(clks_per_bit);
    localparam int idx_w = $clog2(frame_bits);

    typedef logic [data_bits-1:0] byte_t;
    typedef logic [cnt_w-1:0]     cnt_t;            // cycles within one bit
    typedef logic [idx_w-1:0]     idx_t;            // bit index within a frame

endpackage

`default_nettype wire

/* hw/uart_reg_pkg.sv */
////////////////////////////////////////////////////////////////////////////
// bus side register map: addresses, status bits, data word type
////////////////////////////////////////////////////////////////////////////
`default_nettype none

package uart_reg_pkg;

    typedef logic [1:0] reg_addr_t;
    typedef logic [7:0] wb_data_t;

    // register addresses
    localparam reg_addr_t addr_txdata = 2'd0;       // write only
    localparam reg_addr_t addr_rxdata = 2'd1;       // read only, read clears flags
    localparam reg_addr_t addr_status = 2'd2;       // read only
    // address 3 reads zero, writes dropped

    // status word bit positions
    localparam int stat_tx_busy = 0;
    localparam int stat_rxne    = 1;
    localparam int stat_ore     = 2;

endpackage

`default_nettype wire

/* hw/uart_rx_if.sv */
////////////////////////////////////////////////////////////////////////////
// receive path bundle between receiver and register block
////////////////////////////////////////////////////////////////////////////
`default_nettype none

interface uart_rx_if;

    uart_cfg_pkg::byte_t data;      // last received byte
    logic                rxne;      // receive not empty
    logic                ore;       // overrun
    logic                clear;     // one cycle, acked rxdata read

    modport receiver (output data, output rxne, output ore, input clear);
    modport regs (input data, input rxne, input ore, output clear);

endinterface

`default_nettype wire

/* hw/uart_tx.sv */
////////////////////////////////////////////////////////////////////////////
// uart transmitter: 8N1 serializer, LSB first
////////////////////////////////////////////////////////////////////////////
`default_nettype none

module uart_tx (
    input  wire                 clk,
    input  wire                 rst_n,
    input  wire uart_cfg_pkg::byte_t tx_data,
    input  wire                 tx_start,
    output logic                tx_busy,
    output logic                tx
);

    uart_cfg_pkg::cnt_t           cnt;      // cycles into current bit
    uart_cfg_pkg::idx_t           bit_idx;  // 0 is start, frame_bits-1 is stop
    logic [uart_cfg_pkg::data_bits:0] shreg;  // data bits with stop on top
    logic                         bit_end;

    assign bit_end = (cnt == uart_cfg_pkg::cnt_t'(uart_cfg_pkg::clks_per_bit - 1));

    ////////////////////////////////////////////////////////////////////////////
    // bit timing and line driver
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            tx_busy <= 1'b0;
            tx      <= 1'b1;                // line idles high
            cnt     <= '0;
            bit_idx <= '0;
        end else if (!tx_busy) begin
            cnt     <= '0;
            bit_idx <= '0;
            if (tx_start) begin
                tx_busy <= 1'b1;
                tx      <= 1'b0;            // start bit next cycle
            end
        end else if (bit_end) begin
            cnt <= '0;
            if (bit_idx == uart_cfg_pkg::idx_t'(uart_cfg_pkg::frame_bits - 1)) begin
                tx_busy <= 1'b0;            // stop bit done
                tx      <= 1'b1;
            end else begin
                tx      <= shreg[0];
                bit_idx <= bit_idx + 1'b1;
            end
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

    // frame payload, shifted out one bit per period
    always_ff @(posedge clk) begin
        if (!tx_busy && tx_start) begin
            shreg <= {1'b1, tx_data};
        end else if (tx_busy && bit_end) begin
            shreg <= shreg >> 1;
        end
    end

endmodule

`default_nettype wire

/* hw/uart_rx.sv */
////////////////////////////////////////////////////////////////////////////
// uart receiver: synchronizer, mid-bit sampling FSM, rxne and overrun flags
////////////////////////////////////////////////////////////////////////////
`default_nettype none

module uart_rx (
    input  wire  clk,
    input  wire  rst_n,
    input  wire  rx,
    uart_rx_if.receiver rx_bus
);

    typedef enum logic [1:0] {
        st_idle,
        st_start,
        st_data,
        st_stop
    } state_t;

    logic               rx_meta;
    logic               rx_s;       // synchronized line
    state_t             state;
    uart_cfg_pkg::cnt_t cnt;
    uart_cfg_pkg::idx_t bit_idx;
    uart_cfg_pkg::byte_t shreg;
    logic               load;       // byte landed last cycle
    logic               half_end;
    logic               bit_end;

    assign half_end = (cnt == uart_cfg_pkg::cnt_t'(uart_cfg_pkg::clks_per_bit / 2 - 1));
    assign bit_end  = (cnt == uart_cfg_pkg::cnt_t'(uart_cfg_pkg::clks_per_bit - 1));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rx_meta <= 1'b1;
            rx_s    <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_s    <= rx_meta;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // frame FSM
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state   <= st_idle;
            cnt     <= '0;
            bit_idx <= '0;
            load    <= 1'b0;
        end else begin
            load <= 1'b0;
            case (state)
                st_idle: begin
                    cnt     <= '0;
                    bit_idx <= '0;
                    if (!rx_s) state <= st_start;       // falling edge seen
                end
                st_start: begin
                    if (half_end) begin
                        cnt   <= '0;
                        state <= rx_s ? st_idle : st_data;  // glitch check
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                st_data: begin
                    if (bit_end) begin
                        cnt     <= '0;
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == uart_cfg_pkg::idx_t'(uart_cfg_pkg::data_bits - 1))
                            state <= st_stop;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                default: begin                          // st_stop
                    if (bit_end) begin
                        cnt   <= '0;
                        load  <= rx_s;                  // low stop drops the frame
                        state <= st_idle;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_data && bit_end)
            shreg <= {rx_s, shreg[uart_cfg_pkg::data_bits-1:1]};    // LSB first
        if (state == st_stop && bit_end && rx_s)
            rx_bus.data <= shreg;
    end

    // flags, a new byte beats a same-cycle clear
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rx_bus.rxne <= 1'b0;
            rx_bus.ore  <= 1'b0;
        end else if (load) begin
            rx_bus.rxne <= 1'b1;
            if (rx_bus.rxne) rx_bus.ore <= 1'b1;   // previous byte never read
        end else if (rx_bus.clear) begin
            rx_bus.rxne <= 1'b0;
            rx_bus.ore  <= 1'b0;
        end
    end

endmodule

`default_nettype wire

/* hw/uart_wb_regs.sv */
////////////////////////////////////////////////////////////////////////////
// wishbone classic slave: txdata, rxdata and status registers
////////////////////////////////////////////////////////////////////////////
`default_nettype none

module uart_wb_regs (
    input  wire                          clk,
    input  wire                          rst_n,
    input  wire                          wb_cyc,
    input  wire                          wb_stb,
    input  wire                          wb_we,
    input  wire uart_reg_pkg::reg_addr_t wb_adr,
    input  wire uart_reg_pkg::wb_data_t  wb_dat_w,
    output uart_reg_pkg::wb_data_t       wb_dat_r,
    output logic                         wb_ack,
    output uart_cfg_pkg::byte_t          tx_data,
    output logic                         tx_start,
    input  wire                          tx_busy,
    uart_rx_if.regs                      rx_bus
);

    logic                   req;        // request not yet acked
    logic                   tx_wr;
    logic                   rx_rd;
    logic                   take;       // request accepted this cycle
    uart_reg_pkg::wb_data_t status;
    uart_reg_pkg::wb_data_t rd_mux;

    assign req   = wb_cyc & wb_stb & ~wb_ack;
    assign tx_wr = wb_we & (wb_adr == uart_reg_pkg::addr_txdata);
    assign rx_rd = ~wb_we & (wb_adr == uart_reg_pkg::addr_rxdata);
    assign take  = req & ~(tx_wr & tx_busy);   // stall writes while a frame goes out

    always_comb begin
        status = '0;
        status[uart_reg_pkg::stat_tx_busy] = tx_busy;
        status[uart_reg_pkg::stat_rxne]    = rx_bus.rxne;
        status[uart_reg_pkg::stat_ore]     = rx_bus.ore;
    end

    always_comb begin
        case (wb_adr)
            uart_reg_pkg::addr_rxdata: rd_mux = rx_bus.data;
            uart_reg_pkg::addr_status: rd_mux = status;
            default:                   rd_mux = '0;    // txdata and addr 3
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // ack and strobes, one cycle after acceptance
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb_ack       <= 1'b0;
            tx_start     <= 1'b0;
            rx_bus.clear <= 1'b0;
        end else begin
            wb_ack       <= take;
            tx_start     <= take & tx_wr;
            rx_bus.clear <= take & rx_rd;
        end
    end

    always_ff @(posedge clk) begin
        if (take)
            wb_dat_r <= rd_mux;            // held for the ack cycle
        if (take && tx_wr)
            tx_data <= wb_dat_w;
    end

endmodule

`default_nettype wire

/* hw/uart_top.sv */
////////////////////////////////////////////////////////////////////////////
// uart top level: wishbone register block, transmitter, receiver
////////////////////////////////////////////////////////////////////////////
`default_nettype none

module uart_top (
    input  wire                          clk,
    input  wire                          rst_n,
    input  wire                          wb_cyc,
    input  wire                          wb_stb,
    input  wire                          wb_we,
    input  wire uart_reg_pkg::reg_addr_t wb_adr,
    input  wire uart_reg_pkg::wb_data_t  wb_dat_w,
    output uart_reg_pkg::wb_data_t       wb_dat_r,
    output logic                         wb_ack,
    input  wire                          rx,
    output logic                         tx
);

    uart_cfg_pkg::byte_t tx_data;
    logic                tx_start;
    logic                tx_busy;

    uart_rx_if rx_bus ();               // receiver to register block

    uart_wb_regs u_regs (
        .clk      (clk),
        .rst_n    (rst_n),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack),
        .tx_data  (tx_data),
        .tx_start (tx_start),
        .tx_busy  (tx_busy),
        .rx_bus   (rx_bus.regs)
    );

    uart_tx u_tx (
        .clk      (clk),
        .rst_n    (rst_n),
        .tx_data  (tx_data),
        .tx_start (tx_start),
        .tx_busy  (tx_busy),
        .tx       (tx)
    );

    uart_rx u_rx (
        .clk    (clk),
        .rst_n  (rst_n),
        .rx     (rx),
        .rx_bus (rx_bus.receiver)
    );

endmodule

`default_nettype wire

/* bench/uart_sva.sv */
////////////////////////////////////////////////////////////////////////////
// bound assertions on wishbone handshake and serial idle level
////////////////////////////////////////////////////////////////////////////
`default_nettype none

module uart_sva (
    input wire                          clk,
    input wire                          rst_n,
    input wire                          wb_cyc,
    input wire                          wb_stb,
    input wire                          wb_we,
    input wire uart_reg_pkg::reg_addr_t wb_adr,
    input wire uart_reg_pkg::wb_data_t  wb_dat_w,
    input wire                          wb_ack,
    input wire                          tx_busy,
    input wire                          tx
);
    timeunit 1ns;
    timeprecision 1ps;

    int fail_cnt = 0;               // assertion failures so far

    ack_in_request: assert property (@(posedge clk) disable iff (!rst_n)
        wb_ack |-> wb_cyc && wb_stb)
        else begin
            fail_cnt++;
            $error("ack seen outside a request");
        end

    ack_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        wb_ack |=> !wb_ack)
        else begin
            fail_cnt++;
            $error("ack held longer than one cycle");
        end

    tx_idle_high: assert property (@(posedge clk) disable iff (!rst_n)
        !tx_busy |-> tx)
        else begin
            fail_cnt++;
            $error("tx low while transmitter idle");
        end

    // master must hold the request until ack
    req_stable: assert property (@(posedge clk) disable iff (!rst_n)
        wb_cyc && wb_stb && !wb_ack |=> $stable(wb_adr) && $stable(wb_we) && $stable(wb_dat_w))
        else begin
            fail_cnt++;
            $error("bus signals changed while a request waited");
        end

endmodule

bind uart_top uart_sva sva (
    .clk(clk), .rst_n(rst_n), .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
    .wb_adr(wb_adr), .wb_dat_w(wb_dat_w), .wb_ack(wb_ack), .tx_busy(tx_busy), .tx(tx)
);

`default_nettype wire

/* bench/uart_checker.sv */
////////////////////////////////////////////////////////////////////////////
// checker: tx line decoder, frame and read data compare, error count
////////////////////////////////////////////////////////////////////////////
`default_nettype none

module uart_checker (
    input  wire                          clk,
    input  wire                          rst_n,
    input  wire                          wb_we,
    input  wire                          wb_ack,
    input  wire uart_reg_pkg::reg_addr_t wb_adr,
    input  wire uart_reg_pkg::wb_data_t  wb_dat_r,
    input  wire                          tx,
    input  wire                          rd_chk,     // expected read data valid
    input  wire uart_reg_pkg::wb_data_t  rd_exp,
    input  wire                          frame_vld,  // acked transmit write
    input  wire [9:0]                    frame_exp,
    output int                           err_cnt,
    output int                           frame_cnt
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int cpb = uart_cfg_pkg::clks_per_bit;

    logic [9:0] exp_q[$];           // frames written, not yet seen
    logic [9:0] cur;
    logic [9:0] dec;                // levels sampled at bit centers
    logic       in_frame;
    logic       prev;
    int         pos;                // cycles since start bit began

    initial begin
        err_cnt   = 0;
        frame_cnt = 0;
        in_frame  = 1'b0;
    end

    always @(posedge clk) begin
        if (rst_n && wb_ack && !wb_we && rd_chk && wb_dat_r !== rd_exp) begin
            err_cnt++;
            $display("Error at %0t ns: wb_dat_r expected %h got %h", $time, rd_exp, wb_dat_r);
        end
        if (rst_n && wb_ack && wb_we && wb_adr == uart_reg_pkg::addr_txdata && in_frame) begin
            err_cnt++;
            $display("transmit write acked at %0t ns before the previous stop bit ended", $time);
        end
        if (frame_vld)
            exp_q.push_back(frame_exp);

        ////////////////////////////////////////////////////////////////////////////
        // serial decode
        ////////////////////////////////////////////////////////////////////////////
        if (!rst_n) begin
            in_frame = 1'b0;
        end else if (!in_frame) begin
            if (tx === 1'b0) begin              // start bit begins
                if (exp_q.size() == 0) begin
                    err_cnt++;
                    $display("frame started on tx at %0t ns with no transmit write", $time);
                    cur = '0;
                end else begin
                    cur = exp_q.pop_front();
                end
                in_frame = 1'b1;
                pos      = 1;
                prev     = 1'b0;
                dec      = '0;
            end
        end else begin
            if (pos % cpb != 0 && tx !== prev) begin
                err_cnt++;
                $display("tx changed inside bit %0d at %0t ns", pos / cpb, $time);
            end
            if (pos % cpb == cpb / 2)
                dec[pos / cpb] = tx;            // bit center
            prev = tx;
            if (pos == uart_cfg_pkg::frame_bits * cpb - 1) begin
                in_frame = 1'b0;
                frame_cnt++;
                if (dec !== cur) begin
                    err_cnt++;
                    $display("Error at %0t ns: tx frame expected %b got %b", $time, cur, dec);
                end
            end
            pos++;
        end
    end

endmodule

`default_nettype wire

/* bench/tb_uart_top.sv */
////////////////////////////////////////////////////////////////////////////
// testbench: clock, reset, bus tasks, loopback stimulus, timeout
////////////////////////////////////////////////////////////////////////////
`default_nettype none

module tb_uart_top;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int cycle_limit =
        40 * uart_cfg_pkg::frame_bits * uart_cfg_pkg::clks_per_bit * 2;
    localparam uart_reg_pkg::wb_data_t busy_m = 8'(1 << uart_reg_pkg::stat_tx_busy);
    localparam uart_reg_pkg::wb_data_t rxne_m = 8'(1 << uart_reg_pkg::stat_rxne);
    localparam uart_reg_pkg::wb_data_t ore_m  = 8'(1 << uart_reg_pkg::stat_ore);

    logic                    clk;
    logic                    rst_n;
    logic                    wb_cyc;
    logic                    wb_stb;
    logic                    wb_we;
    uart_reg_pkg::reg_addr_t wb_adr;
    uart_reg_pkg::wb_data_t  wb_dat_w;
    uart_reg_pkg::wb_data_t  wb_dat_r;
    logic                    wb_ack;
    logic                    rx;
    logic                    tx;
    logic                    loop_en;        // rx follows tx once set
    logic                    rd_chk;
    uart_reg_pkg::wb_data_t  rd_exp;
    logic                    frame_vld;
    logic [9:0]              frame_exp;
    uart_reg_pkg::wb_data_t  d;
    uart_reg_pkg::wb_data_t  last_rx;
    logic [31:0]             seed;
    int                      cycles;
    int                      bench_errs;
    int                      frames_sent;
    int                      chk_errs;
    int                      frames_seen;

    assign rx = loop_en ? tx : 1'b1;         // serial loopback

    always #50 clk = ~clk;

    uart_top uut (.*);

    uart_checker chk (
        .clk, .rst_n, .wb_we, .wb_ack, .wb_adr, .wb_dat_r, .tx, .rd_chk, .rd_exp,
        .frame_vld, .frame_exp, .err_cnt(chk_errs), .frame_cnt(frames_seen)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    // line levels in send order, start bit in bit 0
    function automatic logic [9:0] expected_frame(input uart_cfg_pkg::byte_t b);
        return {1'b1, b, 1'b0};
    endfunction

    task automatic bus_cycle(input logic we, input uart_reg_pkg::reg_addr_t adr,
                             input uart_reg_pkg::wb_data_t dat,
                             output uart_reg_pkg::wb_data_t rdat);
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_w = dat;
        do @(negedge clk); while (!wb_ack);
        rdat = wb_dat_r;
        if (we && adr == uart_reg_pkg::addr_txdata) begin
            frame_exp = expected_frame(dat);
            frame_vld = 1'b1;
            frames_sent++;
        end
        @(negedge clk);                      // drop stb after ack is gone
        wb_cyc    = 1'b0;
        wb_stb    = 1'b0;
        frame_vld = 1'b0;
        rd_chk    = 1'b0;
    endtask

    task automatic write_reg(input uart_reg_pkg::reg_addr_t adr,
                             input uart_reg_pkg::wb_data_t dat);
        bus_cycle(1'b1, adr, dat, d);
    endtask

    task automatic read_check(input uart_reg_pkg::reg_addr_t adr,
                              input uart_reg_pkg::wb_data_t exp);
        rd_exp = exp;
        rd_chk = 1'b1;
        bus_cycle(1'b0, adr, '0, d);
    endtask

    // poll status until the masked bits match
    task automatic wait_status(input uart_reg_pkg::wb_data_t mask,
                               input uart_reg_pkg::wb_data_t want);
        do bus_cycle(1'b0, uart_reg_pkg::addr_status, '0, d); while ((d & mask) != want);
    endtask

    always @(posedge clk) begin
        if (cycles == cycle_limit) begin
            $display("timeout: run stopped after %0d cycles", cycles);
            $display("errors: bench %0d, checker %0d, assertions %0d",
                     bench_errs, chk_errs, uut.sva.fail_cnt);
            $display("Errors found");
            $finish;
        end
        cycles++;
    end

    ////////////////////////////////////////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////////////////////////////////////////
    initial begin
        clk         = 1'b0;
        rst_n       = 1'b0;
        wb_cyc      = 1'b0;
        wb_stb      = 1'b0;
        wb_we       = 1'b0;
        wb_adr      = '0;
        wb_dat_w    = '0;
        loop_en     = 1'b0;
        rd_chk      = 1'b0;
        rd_exp      = '0;
        frame_vld   = 1'b0;
        frame_exp   = '0;
        seed        = 32'h494cfa21;
        cycles      = 0;
        bench_errs  = 0;
        frames_sent = 0;
        repeat (3) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        if (tx !== 1'b1) begin
            bench_errs++;
            $display("Error at %0t ns: tx expected 1 got %b", $time, tx);
        end
        loop_en = 1'b1;
        read_check(uart_reg_pkg::addr_status, '0);
        repeat (20) begin                    // one frame, then read it back
            seed    = xorshift(seed);
            last_rx = seed[7:0];
            write_reg(uart_reg_pkg::addr_txdata, last_rx);
            wait_status(busy_m | rxne_m, rxne_m);
            read_check(uart_reg_pkg::addr_status, rxne_m);
            read_check(uart_reg_pkg::addr_rxdata, last_rx);
            read_check(uart_reg_pkg::addr_status, '0);
        end
        seed = xorshift(seed);               // back to back, second write stalls
        write_reg(uart_reg_pkg::addr_txdata, seed[7:0]);
        seed    = xorshift(seed);
        last_rx = seed[7:0];
        write_reg(uart_reg_pkg::addr_txdata, last_rx);
        wait_status(busy_m | ore_m, ore_m);
        read_check(uart_reg_pkg::addr_status, rxne_m | ore_m);
        read_check(uart_reg_pkg::addr_rxdata, last_rx);
        read_check(uart_reg_pkg::addr_status, '0);
        write_reg(2'd3, 8'hff);              // both writes are dropped
        write_reg(uart_reg_pkg::addr_status, 8'hff);
        read_check(uart_reg_pkg::addr_status, '0);
        read_check(uart_reg_pkg::addr_rxdata, last_rx);
        if (frames_seen != frames_sent) begin
            bench_errs++;
            $display("only %0d of %0d written frames came out on tx", frames_seen, frames_sent);
        end
        $display("errors: bench %0d, checker %0d, assertions %0d",
                 bench_errs, chk_errs, uut.sva.fail_cnt);
        if (bench_errs + chk_errs + uut.sva.fail_cnt == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

endmodule

`default_nettype wire

/* project.f */
hw/uart_cfg_pkg.sv
hw/uart_reg_pkg.sv
hw/uart_rx_if.sv
hw/uart_tx.sv
hw/uart_rx.sv
hw/uart_wb_regs.sv
hw/uart_top.sv
bench/uart_sva.sv
bench/uart_checker.sv
bench/tb_uart_top.sv

/* Bender.yml */
package:
  name: uart_wb

sources:
  - hw/uart_cfg_pkg.sv
  - hw/uart_reg_pkg.sv
  - hw/uart_rx_if.sv
  - hw/uart_tx.sv
  - hw/uart_rx.sv
  - hw/uart_wb_regs.sv
  - hw/uart_top.sv
  - target: test
    files:
      - bench/uart_sva.sv
      - bench/uart_checker.sv
      - bench/tb_uart_top.sv
